/* ind_btb_macros.svh */
// shared widths and sizes for the indirect branch target buffer
// included by every rtl file and by the testbench

`ifndef IND_BTB_MACROS_SVH
`define IND_BTB_MACROS_SVH

// table index and path entry width
`define IND_BTB_IDX_W      8
// number of table entries
`define IND_BTB_DEPTH      256
// stored jump target bits
`define IND_BTB_TGT_W      20
// privilege mode width
`define IND_BTB_PRIV_W     2
// vld + priv + target
`define IND_BTB_ENTRY_W    23
// entries kept in each path history
`define IND_BTB_PATH_NUM   4
// retire slots per cycle
`define IND_BTB_RETIRE_NUM 3
// privilege register comes out of reset in machine mode
`define IND_BTB_PRIV_RST   2'b11

`endif

/* ind_btb_pkg.sv */
// types and the index hash shared by the indirect btb blocks
// modules pull these in with a wildcard import in their body

`include "ind_btb_macros.svh"

package ind_btb_pkg;

    // one table word, seen raw or split into fields
    // raw view is used for the sweep zero write
    typedef union packed {
        logic [`IND_BTB_ENTRY_W-1:0] raw;
        struct packed {
            logic                      vld;
            logic [`IND_BTB_PRIV_W-1:0] priv;
            logic [`IND_BTB_TGT_W-1:0]  target;
        } f;
    } ind_btb_entry_u;

    // path history, entry 0 newest in the low byte
    typedef logic [`IND_BTB_PATH_NUM-1:0][`IND_BTB_IDX_W-1:0] ind_btb_path_t;

    // fold path history with a ghr into a table index
    // entry k supplies index bits 2k+1..2k
    function automatic logic [`IND_BTB_IDX_W-1:0] ind_btb_hash(
        input ind_btb_path_t              path,
        input logic [`IND_BTB_IDX_W-1:0]  hist
    );
        logic [`IND_BTB_IDX_W-1:0] idx;
        idx = '0;
        for (int k = 0; k < `IND_BTB_PATH_NUM; k++) begin
            idx[2*k +: 2] = path[k][2*k +: 2] ^ hist[2*k +: 2];
        end
        return idx;
    endfunction

endpackage

/* ind_btb_mem_if.sv */
// bundle between the controller, the table array and the read stage
// controller drives the request side, array returns registered data

`include "ind_btb_macros.svh"

interface ind_btb_mem_if;
    import ind_btb_pkg::*;

    // shared by read and write, sweep count has priority
    logic [`IND_BTB_IDX_W-1:0] index;
    // never both high
    logic                      wr_en;
    logic                      rd_en;
    ind_btb_entry_u            wdata;
    // valid one edge after rd_en
    ind_btb_entry_u            rdata;

    modport ctrl     (output index, wr_en, rd_en, wdata);
    modport array    (input index, wr_en, rd_en, wdata, output rdata);
    // read stage only needs the enable and the returned word
    modport rd_stage (input rd_en, rdata);

endinterface

/* ind_btb_ctrl.sv */
// control for the indirect btb: invalidation sweep with req/ack handshake,
// read/write arbitration, table index select and write data

`include "ind_btb_macros.svh"

module ind_btb_ctrl (
    input  logic                        dout_update_clk,
    input  logic                        cpurst_b,
    input  logic                        ind_btb_en,
    input  logic                        inv_req,
    input  logic                        jmp_detect,
    input  logic                        check_vld,
    input  logic                        fifo_stall,
    input  logic                        retire0_jmp_mispred,
    input  logic [`IND_BTB_PRIV_W-1:0]  priv_mode,
    input  logic [`IND_BTB_TGT_W-1:0]   retire0_target,
    input  logic [`IND_BTB_IDX_W-1:0]   wr_index,
    input  logic [`IND_BTB_IDX_W-1:0]   rd_index,
    output logic                        inv_on,
    output logic                        inv_ack,
    output logic                        path_clr,
    ind_btb_mem_if.ctrl                 mem
);
    import ind_btb_pkg::*;

    logic [`IND_BTB_IDX_W-1:0] inv_cnt;
    logic                      inv_start;
    logic                      inv_last;
    logic                      inv_fin;
    logic                      wr_vld;
    logic                      rd_req;
    ind_btb_entry_u            wdata_nxt;

    //==============================
    // invalidation sweep
    //==============================
    // new sweep only from the idle phase of the handshake
    assign inv_start = inv_req && !inv_ack && !inv_on && !inv_fin;
    // last entry of the sweep being cleared
    assign inv_last  = inv_on && (inv_cnt == '0);

    always_ff @(posedge dout_update_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            inv_on <= 1'b0;
        end else if (inv_last) begin
            inv_on <= 1'b0;
        end else if (inv_start) begin
            inv_on <= 1'b1;
        end
    end

    // count down from the top entry
    always_ff @(posedge dout_update_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            inv_cnt <= '0;
        end else if (inv_on) begin
            inv_cnt <= inv_cnt - 1'b1;
        end else if (inv_start) begin
            inv_cnt <= {`IND_BTB_IDX_W{1'b1}};
        end
    end

    // one cycle gap between inv_on falling and ack rising
    always_ff @(posedge dout_update_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            inv_fin <= 1'b0;
        end else begin
            inv_fin <= inv_last;
        end
    end

    // ack held until the requester drops inv_req
    always_ff @(posedge dout_update_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            inv_ack <= 1'b0;
        end else if (inv_fin) begin
            inv_ack <= 1'b1;
        end else if (!inv_req) begin
            inv_ack <= 1'b0;
        end
    end

    // both histories are wiped while sweeping
    assign path_clr = inv_on;

    //==============================
    // read / write arbitration
    //==============================
    // retired mispredicted jump updates the table
    assign wr_vld = ind_btb_en && retire0_jmp_mispred;
    // jump detect or ib check wants a prediction
    assign rd_req = ind_btb_en && (jmp_detect || check_vld);

    // sweep > write > read
    assign mem.wr_en = inv_on || wr_vld;
    assign mem.rd_en = rd_req && !wr_vld && !fifo_stall && !inv_on;

    // index follows the same priority
    assign mem.index = inv_on ? inv_cnt :
                       wr_vld ? wr_index : rd_index;

    //==============================
    // write data
    //==============================
    always_comb begin
        if (inv_on) begin
            wdata_nxt.raw = '0;
        end else begin
            wdata_nxt.f.vld    = 1'b1;
            wdata_nxt.f.priv   = priv_mode;
            wdata_nxt.f.target = retire0_target;
        end
    end

    assign mem.wdata = wdata_nxt;

endmodule

/* ind_btb_rtu_path.sv */
// retire side path history, shifted by up to three retiring jumps a cycle
// also folds the history with the retire ghr into the table write index

`include "ind_btb_macros.svh"

module ind_btb_rtu_path (
    input  logic                                          dout_update_clk,
    input  logic                                          cpurst_b,
    input  logic                                          ind_btb_en,
    input  logic                                          path_clr,
    input  logic [`IND_BTB_RETIRE_NUM-1:0]                retire_jmp,
    input  logic [`IND_BTB_IDX_W-1:0]                     retire0_chk_idx,
    input  logic [`IND_BTB_IDX_W-1:0]                     retire1_chk_idx,
    input  logic [`IND_BTB_IDX_W-1:0]                     retire2_chk_idx,
    input  logic [`IND_BTB_IDX_W-1:0]                     rtu_ghr,
    output logic [`IND_BTB_PATH_NUM*`IND_BTB_IDX_W-1:0]   rtu_path_next,
    output logic [`IND_BTB_IDX_W-1:0]                     wr_index
);
    import ind_btb_pkg::*;

    ind_btb_path_t                                     path_q;
    ind_btb_path_t                                     path_nxt;
    logic [`IND_BTB_RETIRE_NUM-1:0][`IND_BTB_IDX_W-1:0] chk_idx;
    logic                                              path_upd;

    // slot 0 is the oldest retiring instruction
    assign chk_idx = {retire2_chk_idx, retire1_chk_idx, retire0_chk_idx};

    //==============================
    // multi-jump shift
    //==============================
    // walk slots oldest first, each jump pushes one entry in at the bottom
    // so the youngest jumping slot ends up in entry 0
    always_comb begin
        path_nxt = path_q;
        for (int i = 0; i < `IND_BTB_RETIRE_NUM; i++) begin
            if (retire_jmp[i]) begin
                path_nxt = {path_nxt[`IND_BTB_PATH_NUM-2:0], chk_idx[i]};
            end
        end
    end

    // spec path recovers from this, taken or not
    assign rtu_path_next = path_nxt;

    assign path_upd = ind_btb_en && (|retire_jmp);

    always_ff @(posedge dout_update_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            path_q <= '0;
        end else if (path_clr) begin
            path_q <= '0;
        end else if (path_upd) begin
            path_q <= path_nxt;
        end
    end

    //==============================
    // write index
    //==============================
    assign wr_index = ind_btb_hash(path_q, rtu_ghr);

endmodule

/* ind_btb_spec_path.sv */
// speculative path history, shifted by the ib check and recovered
// from the retire side on mispredict or flush; gives the read index

`include "ind_btb_macros.svh"

module ind_btb_spec_path (
    input  logic                                          dout_update_clk,
    input  logic                                          cpurst_b,
    input  logic                                          ind_btb_en,
    input  logic                                          path_clr,
    input  logic                                          retire0_mispred,
    input  logic                                          flush,
    input  logic                                          check_vld,
    input  logic [`IND_BTB_IDX_W-1:0]                     ib_path,
    input  logic [`IND_BTB_PATH_NUM*`IND_BTB_IDX_W-1:0]   rtu_path_next,
    input  logic [`IND_BTB_IDX_W-1:0]                     vghr,
    output logic [`IND_BTB_IDX_W-1:0]                     rd_index
);
    import ind_btb_pkg::*;

    ind_btb_path_t path_q;
    logic          recover;

    // any retire mispredict or flush throws the speculative path away
    assign recover = retire0_mispred || flush;

    always_ff @(posedge dout_update_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            path_q <= '0;
        end else if (path_clr) begin
            path_q <= '0;
        end else if (ind_btb_en && recover) begin
            // take the retire history including this cycle's jumps
            path_q <= rtu_path_next;
        end else if (ind_btb_en && check_vld) begin
            path_q <= {path_q[`IND_BTB_PATH_NUM-2:0], ib_path};
        end
    end

    //==============================
    // read index
    //==============================
    assign rd_index = ind_btb_hash(path_q, vghr);

endmodule

/* ind_btb_array.sv */
// 256 x 23 table storage for the indirect btb
// single port, synchronous write and registered read

`include "ind_btb_macros.svh"

module ind_btb_array (
    input  logic         dout_update_clk,
    ind_btb_mem_if.array mem
);
    import ind_btb_pkg::*;

    // storage, cleared only by the invalidation sweep
    ind_btb_entry_u mem_q [`IND_BTB_DEPTH];

    always_ff @(posedge dout_update_clk) begin
        if (mem.wr_en) begin
            mem_q[mem.index] <= mem.wdata;
        end
    end

    // read data held until the next read
    always_ff @(posedge dout_update_clk) begin
        if (mem.rd_en) begin
            mem.rdata <= mem_q[mem.index];
        end
    end

endmodule

/* ind_btb_rdata.sv */
// read return stage: flops the read enable, then loads the output word
// and the privilege mode in effect at that edge

`include "ind_btb_macros.svh"

module ind_btb_rdata (
    input  logic                        dout_update_clk,
    input  logic                        cpurst_b,
    input  logic [`IND_BTB_PRIV_W-1:0]  priv_mode,
    output logic [`IND_BTB_ENTRY_W-1:0] dout,
    output logic [`IND_BTB_PRIV_W-1:0]  dout_priv_mode,
    ind_btb_mem_if.rd_stage             mem
);
    import ind_btb_pkg::*;

    logic                       rd_flop;
    ind_btb_entry_u             dout_q;
    logic [`IND_BTB_PRIV_W-1:0] priv_q;

    // array data is valid the cycle after the read
    always_ff @(posedge dout_update_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            rd_flop <= 1'b0;
        end else begin
            rd_flop <= mem.rd_en;
        end
    end

    // output word, holds between reads
    always_ff @(posedge dout_update_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            dout_q.raw <= '0;
        end else if (rd_flop) begin
            dout_q <= mem.rdata;
        end
    end

    // privilege captured with the data
    always_ff @(posedge dout_update_clk or negedge cpurst_b) begin
        if (!cpurst_b) begin
            priv_q <= `IND_BTB_PRIV_RST;
        end else if (rd_flop) begin
            priv_q <= priv_mode;
        end
    end

    assign dout           = dout_q.raw;
    assign dout_priv_mode = priv_q;

endmodule

/* ind_btb_top.sv */
// indirect branch target buffer top level with plain ports
// ties controller, both path histories, table and read stage together

`include "ind_btb_macros.svh"

module ind_btb_top (
    input  logic                           dout_update_clk,
    input  logic                           cpurst_b,
    input  logic                           ind_btb_en,
    input  logic                           inv_req,
    input  logic                           jmp_detect,
    input  logic                           check_vld,
    input  logic                           fifo_stall,
    input  logic                           retire0_jmp_mispred,
    input  logic                           retire0_mispred,
    input  logic                           flush,
    input  logic [`IND_BTB_PRIV_W-1:0]     priv_mode,
    input  logic [`IND_BTB_TGT_W-1:0]      retire0_target,
    input  logic [`IND_BTB_RETIRE_NUM-1:0] retire_jmp,
    input  logic [`IND_BTB_IDX_W-1:0]      retire0_chk_idx,
    input  logic [`IND_BTB_IDX_W-1:0]      retire1_chk_idx,
    input  logic [`IND_BTB_IDX_W-1:0]      retire2_chk_idx,
    input  logic [`IND_BTB_IDX_W-1:0]      rtu_ghr,
    input  logic [`IND_BTB_IDX_W-1:0]      ib_path,
    input  logic [`IND_BTB_IDX_W-1:0]      vghr,
    output logic                           inv_on,
    output logic                           inv_ack,
    output logic [`IND_BTB_ENTRY_W-1:0]    dout,
    output logic [`IND_BTB_PRIV_W-1:0]     dout_priv_mode
);

    logic [`IND_BTB_IDX_W-1:0]                   wr_index;
    logic [`IND_BTB_IDX_W-1:0]                   rd_index;
    logic [`IND_BTB_PATH_NUM*`IND_BTB_IDX_W-1:0] rtu_path_next;
    logic                                        path_clr;

    //==============================
    // table request bundle
    //==============================
    ind_btb_mem_if mem_if ();

    ind_btb_ctrl ind_btb_ctrl_i (
        .dout_update_clk     (dout_update_clk),
        .cpurst_b            (cpurst_b),
        .ind_btb_en          (ind_btb_en),
        .inv_req             (inv_req),
        .jmp_detect          (jmp_detect),
        .check_vld           (check_vld),
        .fifo_stall          (fifo_stall),
        .retire0_jmp_mispred (retire0_jmp_mispred),
        .priv_mode           (priv_mode),
        .retire0_target      (retire0_target),
        .wr_index            (wr_index),
        .rd_index            (rd_index),
        .inv_on              (inv_on),
        .inv_ack             (inv_ack),
        .path_clr            (path_clr),
        .mem                 (mem_if.ctrl)
    );

    //==============================
    // path histories
    //==============================
    ind_btb_rtu_path ind_btb_rtu_path_i (
        .dout_update_clk (dout_update_clk),
        .cpurst_b        (cpurst_b),
        .ind_btb_en      (ind_btb_en),
        .path_clr        (path_clr),
        .retire_jmp      (retire_jmp),
        .retire0_chk_idx (retire0_chk_idx),
        .retire1_chk_idx (retire1_chk_idx),
        .retire2_chk_idx (retire2_chk_idx),
        .rtu_ghr         (rtu_ghr),
        .rtu_path_next   (rtu_path_next),
        .wr_index        (wr_index)
    );

    ind_btb_spec_path ind_btb_spec_path_i (
        .dout_update_clk (dout_update_clk),
        .cpurst_b        (cpurst_b),
        .ind_btb_en      (ind_btb_en),
        .path_clr        (path_clr),
        .retire0_mispred (retire0_mispred),
        .flush           (flush),
        .check_vld       (check_vld),
        .ib_path         (ib_path),
        .rtu_path_next   (rtu_path_next),
        .vghr            (vghr),
        .rd_index        (rd_index)
    );

    //==============================
    // storage and read return
    //==============================
    ind_btb_array ind_btb_array_i (
        .dout_update_clk (dout_update_clk),
        .mem             (mem_if.array)
    );

    ind_btb_rdata ind_btb_rdata_i (
        .dout_update_clk (dout_update_clk),
        .cpurst_b        (cpurst_b),
        .priv_mode       (priv_mode),
        .dout            (dout),
        .dout_priv_mode  (dout_priv_mode),
        .mem             (mem_if.rd_stage)
    );

endmodule

/* tb_ind_btb.sv */
// self-checking testbench for the indirect branch target buffer
// replays ind_btb_tests.txt against a reference model of the table and both paths

`include "ind_btb_macros.svh"

module tb_ind_btb;
    import ind_btb_pkg::*;

    localparam int FIELDS    = 6;
    localparam int MAX_LINES = 64;

    logic                           dout_update_clk = 1'b0;
    logic                           cpurst_b;
    logic                           ind_btb_en;
    logic                           inv_req;
    logic                           jmp_detect;
    logic                           check_vld;
    logic                           fifo_stall;
    logic                           retire0_jmp_mispred;
    logic                           retire0_mispred;
    logic                           flush;
    logic [`IND_BTB_PRIV_W-1:0]     priv_mode;
    logic [`IND_BTB_TGT_W-1:0]      retire0_target;
    logic [`IND_BTB_RETIRE_NUM-1:0] retire_jmp;
    logic [`IND_BTB_IDX_W-1:0]      retire0_chk_idx;
    logic [`IND_BTB_IDX_W-1:0]      retire1_chk_idx;
    logic [`IND_BTB_IDX_W-1:0]      retire2_chk_idx;
    logic [`IND_BTB_IDX_W-1:0]      rtu_ghr;
    logic [`IND_BTB_IDX_W-1:0]      ib_path;
    logic [`IND_BTB_IDX_W-1:0]      vghr;
    logic                           inv_on;
    logic                           inv_ack;
    logic [`IND_BTB_ENTRY_W-1:0]    dout;
    logic [`IND_BTB_PRIV_W-1:0]     dout_priv_mode;

    // six hex words per test line
    logic [31:0]    tmem [FIELDS*MAX_LINES];

    // reference state
    ind_btb_entry_u model_mem [`IND_BTB_DEPTH];
    logic [31:0]    rtu_hist;
    logic [31:0]    spec_hist;
    ind_btb_entry_u exp_dout;
    logic [1:0]     exp_priv;
    logic [1:0]     last_priv;
    // reads in flight, two edges to dout
    logic           p1_vld;
    logic           p2_vld;
    ind_btb_entry_u p1_data;
    ind_btb_entry_u p2_data;

    // levels held across test lines
    logic           en_val;
    logic           stall_val;
    logic           req_val;
    logic [1:0]     priv_val;
    // inputs for the next cycle only
    logic [2:0]     c_jmp;
    logic [23:0]    c_chk;
    logic [7:0]     c_ghr;
    logic [1:0]     c_misp;
    logic           c_jdet;
    logic           c_check;
    logic           c_flush;
    logic [7:0]     c_ib;
    logic [7:0]     c_vghr;
    logic [19:0]    c_tgt;

    integer         seed;
    int             err_cnt = 0;
    int             other_cnt = 0;
    int             check_cnt = 0;
    int             cycle_cnt = 0;
    int             cycle_limit = 0;

    ind_btb_top ind_btb_top_i (.*);

    always #50 dout_update_clk = ~dout_update_clk;

    // watchdog, limit set once the test file is counted
    always @(posedge dout_update_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("run stopped, no progress after %0d cycles", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    //==============================
    // reference rules
    //==============================
    // index bits 2k+1..2k taken from path entry k, then xor with the history
    function automatic logic [7:0] fold_index(input logic [31:0] hist, input logic [7:0] ghr);
        logic [7:0] sel;
        sel = (hist[7:0] & 8'h03) | (hist[15:8] & 8'h0c) |
              (hist[23:16] & 8'h30) | (hist[31:24] & 8'hc0);
        return sel ^ ghr;
    endfunction

    // oldest slot pushed first, so the youngest jump ends in entry 0
    function automatic logic [31:0] shift_path(input logic [31:0] hist, input logic [2:0] jmp,
                                               input logic [23:0] chk);
        logic [31:0] h;
        h = hist;
        for (int i = 0; i < 3; i++) begin
            if (jmp[i]) begin
                h = {h[23:0], chk[8*i +: 8]};
            end
        end
        return h;
    endfunction

    task automatic check_entry(input string name, input ind_btb_entry_u got,
                               input ind_btb_entry_u exp);
        check_cnt++;
        if (got.raw !== exp.raw) begin
            err_cnt++;
            $display("** Error: %s got 0x%06h expected 0x%06h at %0t", name, got.raw, exp.raw,
                     $time);
        end
    endtask

    task automatic check_bits(input string name, input logic [1:0] got, input logic [1:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic note_failure(input string msg);
        other_cnt++;
        $display("%s", msg);
    endtask

    //==============================
    // one clock of stimulus
    //==============================
    task automatic drive_cycle();
        logic           wr;
        logic           rd;
        logic [31:0]    nxt;
        ind_btb_entry_u wentry;
        ind_btb_entry_u got;
        @(posedge dout_update_clk);
        // this edge loads dout from the read two cycles back
        if (p2_vld) begin
            exp_dout = p2_data;
            exp_priv = last_priv;
        end
        p2_vld  = p1_vld;
        p2_data = p1_data;
        ind_btb_en          <= en_val;
        fifo_stall          <= stall_val;
        priv_mode           <= priv_val;
        inv_req             <= req_val;
        retire_jmp          <= c_jmp;
        retire0_chk_idx     <= c_chk[7:0];
        retire1_chk_idx     <= c_chk[15:8];
        retire2_chk_idx     <= c_chk[23:16];
        rtu_ghr             <= c_ghr;
        retire0_jmp_mispred <= c_misp[0];
        retire0_mispred     <= c_misp[1];
        retire0_target      <= c_tgt;
        jmp_detect          <= c_jdet;
        check_vld           <= c_check;
        flush               <= c_flush;
        ib_path             <= c_ib;
        vghr                <= c_vghr;
        // write wins over read, stall only drops the read
        wr = en_val && c_misp[0];
        rd = en_val && (c_jdet || c_check) && !wr && !stall_val;
        if (wr) begin
            wentry.f.vld    = 1'b1;
            wentry.f.priv   = priv_val;
            wentry.f.target = c_tgt;
            model_mem[fold_index(rtu_hist, c_ghr)] = wentry;
        end
        p1_vld  = rd;
        p1_data = model_mem[fold_index(spec_hist, c_vghr)];
        nxt = shift_path(rtu_hist, c_jmp, c_chk);
        if (en_val && (c_misp[1] || c_flush)) begin
            spec_hist = nxt;
        end else if (en_val && c_check) begin
            spec_hist = {spec_hist[23:0], c_ib};
        end
        if (en_val && (|c_jmp)) begin
            rtu_hist = nxt;
        end
        last_priv = priv_val;
        {c_jmp, c_chk, c_ghr, c_misp, c_jdet, c_check, c_flush, c_ib, c_vghr, c_tgt} = '0;
        @(negedge dout_update_clk);
        got.raw = dout;
        check_entry("dout", got, exp_dout);
        check_bits("dout_priv_mode", dout_priv_mode, exp_priv);
    endtask

    // full four-phase sweep with edge-exact flag checks
    task automatic run_invalidate(input int exp_cycles);
        int waited;
        int on_cycles;
        req_val = 1'b1;
        drive_cycle();
        waited = 0;
        while (!inv_on && waited < 4) begin
            drive_cycle();
            waited++;
        end
        if (!inv_on) begin
            note_failure("inv_on never rose after inv_req went high");
        end
        on_cycles = 0;
        while (inv_on && on_cycles < 300) begin
            on_cycles++;
            drive_cycle();
        end
        if (on_cycles != exp_cycles) begin
            err_cnt++;
            $display("** Error: inv_on high cycles got 0x%0h expected 0x%0h", on_cycles,
                     exp_cycles);
        end
        // ack one edge after inv_on falls
        check_bits("inv_on/inv_ack", {inv_on, inv_ack}, 2'b00);
        drive_cycle();
        check_bits("inv_on/inv_ack", {inv_on, inv_ack}, 2'b01);
        req_val = 1'b0;
        drive_cycle();
        check_bits("inv_on/inv_ack", {inv_on, inv_ack}, 2'b01);
        drive_cycle();
        check_bits("inv_on/inv_ack", {inv_on, inv_ack}, 2'b00);
        for (int i = 0; i < `IND_BTB_DEPTH; i++) begin
            model_mem[i].raw = '0;
        end
        rtu_hist  = '0;
        spec_hist = '0;
    endtask

    //==============================
    // test sequence
    //==============================
    initial begin
        logic [31:0]    op;
        logic [31:0]    f1;
        logic [31:0]    f2;
        logic [31:0]    f3;
        logic [31:0]    f4;
        logic [31:0]    f5;
        int             n_lines;
        ind_btb_entry_u got;
        ind_btb_entry_u want;
        cpurst_b = 1'b0;
        {ind_btb_en, inv_req, jmp_detect, check_vld, fifo_stall} = '0;
        {retire0_jmp_mispred, retire0_mispred, flush, retire_jmp} = '0;
        {retire0_chk_idx, retire1_chk_idx, retire2_chk_idx, rtu_ghr, ib_path, vghr} = '0;
        retire0_target = '0;
        priv_mode      = `IND_BTB_PRIV_RST;
        seed      = 32'h4e6659ea;
        en_val    = 1'b0;
        stall_val = 1'b0;
        req_val   = 1'b0;
        priv_val  = `IND_BTB_PRIV_RST;
        {c_jmp, c_chk, c_ghr, c_misp, c_jdet, c_check, c_flush, c_ib, c_vghr, c_tgt} = '0;
        for (int i = 0; i < `IND_BTB_DEPTH; i++) begin
            model_mem[i].raw = '0;
        end
        rtu_hist      = '0;
        spec_hist     = '0;
        exp_dout.raw  = '0;
        exp_priv      = `IND_BTB_PRIV_RST;
        last_priv     = `IND_BTB_PRIV_RST;
        {p1_vld, p2_vld, p1_data, p2_data} = '0;

        $readmemh("ind_btb_tests.txt", tmem);
        n_lines = 0;
        while (n_lines < MAX_LINES && tmem[FIELDS*n_lines] !== 32'hf) begin
            n_lines++;
        end
        if (n_lines == MAX_LINES) begin
            note_failure("test file has no end line");
        end
        cycle_limit = 300 * n_lines + 1000;

        repeat (2) @(posedge dout_update_clk);
        cpurst_b <= 1'b1;

        for (int ln = 0; ln < n_lines; ln++) begin
            op = tmem[FIELDS*ln];
            f1 = tmem[FIELDS*ln+1];
            f2 = tmem[FIELDS*ln+2];
            f3 = tmem[FIELDS*ln+3];
            f4 = tmem[FIELDS*ln+4];
            f5 = tmem[FIELDS*ln+5];
            case (op)
                32'h0: begin
                    drive_cycle();
                    got.raw  = dout;
                    want.raw = f1[22:0];
                    check_entry("dout", got, want);
                    check_bits("dout_priv_mode", dout_priv_mode, f2[1:0]);
                    check_bits("inv_on/inv_ack", {inv_on, inv_ack}, f3[1:0]);
                end
                32'h1: run_invalidate(f1);
                32'h2: begin
                    c_jmp  = f1[2:0];
                    c_chk  = f2[23:0];
                    c_ghr  = f3[7:0];
                    c_misp = f4[1:0];
                    c_jdet = f5[0];
                    c_vghr = f5[15:8];
                    c_tgt  = 20'($random(seed));
                    drive_cycle();
                end
                32'h3: begin
                    c_check = 1'b1;
                    c_ib    = f1[7:0];
                    c_vghr  = f2[7:0];
                    drive_cycle();
                end
                32'h4: begin
                    c_flush = 1'b1;
                    drive_cycle();
                end
                32'h5: begin
                    c_jdet = 1'b1;
                    c_vghr = f1[7:0];
                    repeat (3) drive_cycle();
                    got.raw = dout;
                    check_bits("dout.vld", {1'b0, got.f.vld}, {1'b0, f2[0]});
                    check_bits("dout_priv_mode", dout_priv_mode, f3[1:0]);
                end
                32'h6: begin
                    en_val    = f1[0];
                    stall_val = f2[0];
                    priv_val  = f3[1:0];
                    drive_cycle();
                end
                default: note_failure($sformatf("unknown operation 0x%0h on test line %0d", op, ln));
            endcase
        end

        $display("checks: %0d, value errors: %0d, other errors: %0d", check_cnt, err_cnt,
                 other_cnt);
        if (err_cnt == 0 && other_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* ind_btb_tests.txt */
// op f1 f2 f3 f4 f5 in hex: 0 rst dout priv flags, 1 inv cycles, 2 retire jmp chk ghr misp vghr_jdet
// 3 check ib vghr, 4 flush, 5 read vghr exp_vld exp_priv, 6 ctrl en stall priv, f end
0 0      3 0  0 0
6 1      0 1  0 0
1 100    0 0  0 0
5 5a     0 1  0 0
2 1      11 0  0 0
2 0      0 3c 1 0
3 11     0 0  0 0
5 3c     1 1  0 0
6 1      0 2  0 0
5 3c     1 2  0 0
// two then three jumps, write, then recover
2 3      99c233 0 0 0
2 7      665544 0 0 0
2 0      0 81 1 0
4 0      0 0  0 0
5 81     1 2  0 0
// blocking by enable, stall and a same-cycle write
6 0      0 2  0 0
2 0      0 0  1 0
5 5a     1 2  0 0
6 1      0 2  0 0
5 0      0 2  0 0
5 81     1 2  0 0
6 1      1 3  0 0
5 5a     1 2  0 0
6 1      0 3  0 0
5 5a     0 3  0 0
2 0      0 0  1 8101
5 0      1 3  0 0
1 100    0 0  0 0
5 47     0 3  0 0
f 0      0 0  0 0

/* src.f */
+incdir+.
ind_btb_pkg.sv
ind_btb_mem_if.sv
ind_btb_ctrl.sv
ind_btb_rtu_path.sv
ind_btb_spec_path.sv
ind_btb_array.sv
ind_btb_rdata.sv
ind_btb_top.sv
tb_ind_btb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and grade the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ind_btb -f src.f -o tb_ind_btb \
    && ./obj_dir/tb_ind_btb > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
